// ==== Bender.yml ====
package:
  name: operand_read

sources:
  - files:
      - design/rvseed_pkg.sv
      - design/regfile.sv
      - design/hazard_detect.sv
      - design/operand_forward.sv
      - design/operand_read_top.sv

  - target: simulation
    files:
      - verification/operand_read_properties.sv
      - verification/operand_read_tb.sv

// ==== design/hazard_detect.sv ====
`timescale 1ns/100ps

module hazard_detect (
    input  rvseed_pkg::operand_req_t req,
    input  rvseed_pkg::stage_dst_t   ex_dst,
    input  rvseed_pkg::stage_dst_t   mem_dst,
    input  rvseed_pkg::stage_dst_t   wb_dst,
    output rvseed_pkg::fwd_sel_t     sel1,
    output rvseed_pkg::fwd_sel_t     sel2,
    output logic                     stall
);
    import rvseed_pkg::*;

    logic rs1_ex;
    logic rs1_mem;
    logic rs1_wb;
    logic rs2_ex;
    logic rs2_mem;
    logic rs2_wb;
    logic load_dep_rs1;
    logic load_dep_rs2;

    // stage holds a live result for this source, never x0
    function automatic logic dst_hit(input reg_addr_t src, input stage_dst_t dst);
        logic addr_eq;
        addr_eq = (dst.rd == src);
        return dst.valid && addr_eq && (src != '0);
    endfunction

    // youngest result wins
    function automatic fwd_sel_t pick_sel(
        input logic on_ex,
        input logic on_mem,
        input logic on_wb
    );
        fwd_sel_t sel;
        if (on_ex) begin
            sel = sel_ex;
        end else if (on_mem) begin
            sel = sel_mem;
        end else if (on_wb) begin
            sel = sel_wb;
        end else begin
            sel = sel_rf;
        end
        return sel;
    endfunction

    // source 1 against each stage
    assign rs1_ex  = dst_hit(req.rs1, ex_dst);
    assign rs1_mem = dst_hit(req.rs1, mem_dst);
    assign rs1_wb  = dst_hit(req.rs1, wb_dst);

    // source 2 against each stage
    assign rs2_ex  = dst_hit(req.rs2, ex_dst);
    assign rs2_mem = dst_hit(req.rs2, mem_dst);
    assign rs2_wb  = dst_hit(req.rs2, wb_dst);

    assign sel1 = pick_sel(rs1_ex, rs1_mem, rs1_wb);
    assign sel2 = pick_sel(rs2_ex, rs2_mem, rs2_wb);

    // load data arrives from memory one cycle later,
    // so a load in execute cannot be forwarded yet
    assign load_dep_rs1 = rs1_ex && ex_dst.is_load;
    assign load_dep_rs2 = rs2_ex && ex_dst.is_load && req.use_rs2;

    assign stall = req.valid && (load_dep_rs1 || load_dep_rs2);

endmodule

// ==== design/operand_forward.sv ====
`timescale 1ns/100ps

module operand_forward (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  logic                     stall,
    input  rvseed_pkg::fwd_sel_t     sel1,
    input  rvseed_pkg::fwd_sel_t     sel2,
    input  rvseed_pkg::xdata_t       rf1,
    input  rvseed_pkg::xdata_t       rf2,
    input  rvseed_pkg::xdata_t       ex_data,
    input  rvseed_pkg::xdata_t       mem_data,
    input  rvseed_pkg::xdata_t       wb_data,
    output rvseed_pkg::ex_operands_t ex_ops
);
    import rvseed_pkg::*;

    xdata_t op1_fwd;
    xdata_t op2_fwd;
    logic   load_en;
    logic   valid_q;
    xdata_t op1_q;
    xdata_t op2_q;

    // four-way operand mux, shared by both sources
    function automatic xdata_t pick_operand(
        input fwd_sel_t sel,
        input xdata_t   rf_val,
        input xdata_t   ex_val,
        input xdata_t   mem_val,
        input xdata_t   wb_val
    );
        xdata_t val;
        case (sel)
            sel_ex:  val = ex_val;
            sel_mem: val = mem_val;
            sel_wb:  val = wb_val;
            default: val = rf_val;
        endcase
        return val;
    endfunction

    assign op1_fwd = pick_operand(sel1, rf1, ex_data, mem_data, wb_data);
    assign op2_fwd = pick_operand(sel2, rf2, ex_data, mem_data, wb_data);

    // advance only on a valid request that is not blocked
    assign load_en = req_valid && !stall;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_en;   // bubble when idle or stalled
        end
    end

    // operands hold their last values across a bubble
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1_q <= '0;
            op2_q <= '0;
        end else if (load_en) begin
            op1_q <= op1_fwd;
            op2_q <= op2_fwd;
        end
    end

    assign ex_ops.valid = valid_q;
    assign ex_ops.op1   = op1_q;
    assign ex_ops.op2   = op2_q;

endmodule

// ==== design/operand_read_top.sv ====
`timescale 1ns/100ps

module operand_read_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  rvseed_pkg::operand_req_t req,
    input  rvseed_pkg::stage_dst_t   ex_dst,
    input  rvseed_pkg::stage_dst_t   mem_dst,
    input  rvseed_pkg::stage_dst_t   wb_dst,
    output logic                     stall,
    output rvseed_pkg::ex_operands_t ex_ops
);
    import rvseed_pkg::*;

    fwd_sel_t sel1;
    fwd_sel_t sel2;
    xdata_t   rf1;
    xdata_t   rf2;

    // write port fed straight from write-back
    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wb_dst),
        .rs1   (req.rs1),
        .rs2   (req.rs2),
        .rd1   (rf1),
        .rd2   (rf2)
    );

    hazard_detect u_hazard_detect (
        .req     (req),
        .ex_dst  (ex_dst),
        .mem_dst (mem_dst),
        .wb_dst  (wb_dst),
        .sel1    (sel1),
        .sel2    (sel2),
        .stall   (stall)
    );

    operand_forward u_operand_forward (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req.valid),
        .stall     (stall),
        .sel1      (sel1),
        .sel2      (sel2),
        .rf1       (rf1),
        .rf2       (rf2),
        .ex_data   (ex_dst.data),
        .mem_data  (mem_dst.data),
        .wb_data   (wb_dst.data),
        .ex_ops    (ex_ops)
    );

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/100ps

module regfile (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rvseed_pkg::stage_dst_t wr,
    input  rvseed_pkg::reg_addr_t  rs1,
    input  rvseed_pkg::reg_addr_t  rs2,
    output rvseed_pkg::xdata_t     rd1,
    output rvseed_pkg::xdata_t     rd2
);
    import rvseed_pkg::*;

    // x0 has no storage
    xdata_t regs [1:reg_count-1];
    logic   wr_en;

    // writes to x0 are dropped
    assign wr_en = wr.valid && (wr.rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // asynchronous reads
    always_comb begin
        if (rs1 == '0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[rs2];
        end
    end

endmodule

// ==== design/rvseed_pkg.sv ====
package rvseed_pkg;

    // fixed by the RV64I ISA
    localparam int xlen           = 64;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    typedef logic [reg_addr_width-1:0] reg_addr_t;
    typedef logic [xlen-1:0]           xdata_t;

    // operand request from decode, 12 bits
    typedef struct packed {
        logic      valid;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_rs2;   // rs2 is a real source
    } operand_req_t;

    // result in flight in a later stage, 71 bits
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xdata_t    data;
        logic      is_load;   // only meaningful in execute
    } stage_dst_t;

    // operand source, register file when nothing matches
    typedef enum logic [1:0] {
        sel_rf  = 2'd0,
        sel_ex  = 2'd1,
        sel_mem = 2'd2,
        sel_wb  = 2'd3
    } fwd_sel_t;

    // decode-to-execute operand latch, 129 bits
    typedef struct packed {
        logic   valid;
        xdata_t op1;
        xdata_t op2;
    } ex_operands_t;

endpackage

// ==== verification/operand_read_golden.txt ====
# id(dec) req:valid rs1 rs2 use_rs2 ex:valid rd data is_load mem:valid rd data wb:valid rd data
# expected: stall ex_ops.valid op1 op2 (all hex but id, data of idle stages is ignored)
# 1 reset and plain reads
1 0 00 00 0  0 00 0 0  0 00 0  0 00 0  0 0 0 0
1 0 00 00 0  0 00 0 0  0 00 0  1 01 1111  0 0 0 0
1 0 00 00 0  0 00 0 0  0 00 0  1 02 2222  0 0 0 0
1 0 00 00 0  0 00 0 0  0 00 0  1 00 dead  0 0 0 0
1 1 01 02 1  0 00 0 0  0 00 0  0 00 0  0 1 1111 2222
1 1 00 01 1  0 00 0 0  0 00 0  0 00 0  0 1 0 1111
# 2 single-stage forwarding, wb value in its own write cycle
2 1 03 01 1  1 03 3333 0  0 00 0  0 00 0  0 1 3333 1111
2 1 02 04 1  0 00 0 0  1 04 4444  0 00 0  0 1 2222 4444
2 1 05 00 0  0 00 0 0  0 00 0  1 05 5555  0 1 5555 0
2 1 05 03 1  0 00 0 0  0 00 0  0 00 0  0 1 5555 0
# 3 priority ex over mem over wb, x0 never forwarded
3 1 06 06 1  1 06 6e 0  1 06 6d  1 06 6b  0 1 6e 6e
3 1 06 07 1  1 07 77 0  1 06 7d  1 06 7b  0 1 7d 77
3 1 01 02 1  0 00 0 0  1 02 82  1 01 8b  0 1 8b 82
3 1 00 00 1  1 00 99 0  1 00 98  1 00 97  0 1 0 0
3 1 06 01 1  0 00 0 0  0 00 0  0 00 0  0 1 7b 8b
# 4 load-use stall, then the load data comes from mem
4 1 08 01 1  1 08 0 1  0 00 0  0 00 0  1 0 7b 8b
4 1 08 01 1  0 00 0 0  1 08 a8  0 00 0  0 1 a8 8b
# rs2 unused, so no stall and op2 still takes the ex word
4 1 02 09 0  1 09 ff 1  0 00 0  0 00 0  0 1 2222 ff
4 1 02 09 1  1 09 ff 1  0 00 0  0 00 0  1 0 2222 ff
4 1 02 09 1  0 00 0 0  1 09 a9  0 00 0  0 1 2222 a9
# 5 idle requests
5 0 01 00 0  1 01 bb 1  0 00 0  0 00 0  0 0 2222 a9
5 0 00 00 0  0 00 0 0  0 00 0  0 00 0  0 0 2222 a9
5 1 01 05 1  0 00 0 0  0 00 0  0 00 0  0 1 8b 5555

// ==== verification/operand_read_properties.sv ====
`timescale 1ns/100ps

module operand_read_properties (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     req_valid,
    input logic                     stall,
    input rvseed_pkg::ex_operands_t ex_ops
);

    // a stalled request never reaches execute
    bubble_after_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |=> !ex_ops.valid
    ) else $error("ex_ops valid in the cycle after a stall");

    // operands hold across a bubble
    ops_held_on_bubble: assert property (
        @(posedge clk) disable iff (!rst_n)
        $fell(ex_ops.valid) |-> ($stable(ex_ops.op1) && $stable(ex_ops.op2))
    ) else $error("operands changed when ex_ops valid fell");

    stall_needs_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        stall |-> req_valid
    ) else $error("stall high without a valid request");

endmodule

bind operand_forward operand_read_properties u_properties (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .stall     (stall),
    .ex_ops    (ex_ops)
);

// ==== verification/operand_read_tb.sv ====
`timescale 1ns/100ps

module operand_read_tb;
    import rvseed_pkg::*;

    localparam int    clk_period  = 20;
    localparam int    rst_cycles  = 5;
    localparam string golden_path = "verification/operand_read_golden.txt";

    // one line of the golden file
    typedef struct packed {
        logic [31:0]  id;
        operand_req_t req;
        stage_dst_t   ex_dst;
        stage_dst_t   mem_dst;
        stage_dst_t   wb_dst;
        logic         stall;
        ex_operands_t ops;
    } vector_t;

    logic         clk;
    logic         rst_n;
    operand_req_t req;
    stage_dst_t   ex_dst;
    stage_dst_t   mem_dst;
    stage_dst_t   wb_dst;
    logic         stall;
    ex_operands_t ex_ops;

    vector_t vecs [$];
    int      test_errs;
    int      tests_passed;
    int      tests_failed;
    int      cycles;
    int      cycle_limit;
    bit      loaded = 1'b0;

    operand_read_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (req),
        .ex_dst  (ex_dst),
        .mem_dst (mem_dst),
        .wb_dst  (wb_dst),
        .stall   (stall),
        .ex_ops  (ex_ops)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic load_vectors();
        int               fd;
        int               n;
        logic [8*200-1:0] line;
        logic [31:0]      id;
        logic             rv, u2, exv, exl, mv, wv, es, ov;
        logic [4:0]       rs1, rs2, exrd, mrd, wrd;
        logic [63:0]      exd, md, wd, op1, op2;
        vector_t          v;
        fd = $fopen(golden_path, "r");
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = '0;
                n = $fgets(line, fd);
                n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            id, rv, rs1, rs2, u2, exv, exrd, exd, exl, mv, mrd, md,
                            wv, wrd, wd, es, ov, op1, op2);
                if (n == 19) begin   // comment and blank lines fall through
                    v.id      = id;
                    v.req     = '{rv, rs1, rs2, u2};
                    v.ex_dst  = '{exv, exrd, exd, exl};
                    v.mem_dst = '{mv, mrd, md, 1'b0};
                    v.wb_dst  = '{wv, wrd, wd, 1'b0};
                    v.stall   = es;
                    v.ops     = '{ov, op1, op2};
                    vecs.push_back(v);
                end
            end
            $fclose(fd);
        end
    endtask

    // drive one vector, idle stages carry scrambled data aimed at the sources
    task automatic apply_vector(input vector_t v);
        req     = v.req;
        ex_dst  = v.ex_dst;
        mem_dst = v.mem_dst;
        wb_dst  = v.wb_dst;
        if (!v.ex_dst.valid) begin
            ex_dst.rd      = v.req.rs1;
            ex_dst.data    = {$urandom, $urandom};
            ex_dst.is_load = 1'b1;   // an idle load must not stall
        end
        if (!v.mem_dst.valid) begin
            mem_dst.rd   = v.req.rs2;
            mem_dst.data = {$urandom, $urandom};
        end
        if (!v.wb_dst.valid) begin
            wb_dst.rd   = v.req.rs1;   // idle write must not reach the regfile
            wb_dst.data = {$urandom, $urandom};
        end
    endtask

    task automatic check_stall(input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED t=%0t stall expected %b actual %b", $time, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_ops(input ex_operands_t exp, input ex_operands_t act);
        if (act !== exp) begin
            $display("FAILED t=%0t ex_ops expected %b/%h/%h actual %b/%h/%h", $time,
                     exp.valid, exp.op1, exp.op2, act.valid, act.op1, act.op2);
            test_errs++;
        end
    endtask

    task automatic finish_test(input int id);
        if (test_errs == 0) begin
            tests_passed++;
            $display("test %0d: ok", id);
        end else begin
            tests_failed++;
            $display("test %0d: %0d mismatches", id, test_errs);
        end
        test_errs = 0;
    endtask

    initial begin
        int unsigned seed_draw;
        vector_t     v;
        int          cur_id;
        seed_draw    = $urandom(32'hee1eb53b);
        rst_n        = 1'b0;
        req          = '0;
        ex_dst       = '0;
        mem_dst      = '0;
        wb_dst       = '0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        load_vectors();
        cycle_limit = 10 * vecs.size() + rst_cycles;
        loaded      = 1'b1;
        repeat (rst_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (vecs.size() == 0) begin
            $display("no vectors could be read from %s", golden_path);
            tests_failed++;
        end else begin
            cur_id = vecs[0].id;
            for (int i = 0; i < vecs.size(); i++) begin
                v = vecs[i];
                if (v.id != cur_id) begin
                    finish_test(cur_id);
                    cur_id = v.id;
                end
                apply_vector(v);
                #(clk_period / 2 - 1);   // stall settled, edge not yet taken
                check_stall(v.stall, stall);
                @(negedge clk);
                check_ops(v.ops, ex_ops);
            end
            finish_test(cur_id);
        end
        $display("tests passed: %0d failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        wait (loaded);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: vectors did not complete");
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog.f ====
design/rvseed_pkg.sv
design/regfile.sv
design/hazard_detect.sv
design/operand_forward.sv
design/operand_read_top.sv
verification/operand_read_properties.sv
verification/operand_read_tb.sv
